/* common/cpc_bus_pkg.sv */
/*
 * Z80 bus types for the RAM expansion card.
 * Data byte, address quadrant and the I/O control codes in data bits 7:6.
 */

package cpc_bus_pkg;

  // One byte on the Z80 data bus
  typedef logic [7:0] bus_data_t;

  // Address bits 15 and 14, naming the 16K quadrant of an access
  typedef logic [1:0] quadrant_t;

  // Data bits 7:6 of an I/O write to the gate array port select the function.
  // 11 selects a RAM bank and block scheme
  localparam logic [1:0] CTRL_CODE_RAM = 2'b11;
  // 10 carries the ROM enable bits and the screen mode
  localparam logic [1:0] CTRL_CODE_ROM = 2'b10;

  // Quadrant 0000-3FFF, shared with the lower ROM
  localparam quadrant_t QUAD_LOW_ROM = 2'b00;
  // Quadrant 4000-7FFF, the only window the bank 1 schemes remap
  localparam quadrant_t QUAD_BANK1 = 2'b01;
  // Quadrant C000-FFFF, shared with the upper ROMs
  localparam quadrant_t QUAD_HIGH_ROM = 2'b11;

endpackage : cpc_bus_pkg

/* common/ram_map_pkg.sv */
/*
 * Expansion RAM mapping types: 64K bank, block scheme,
 * 16K block and the upper SRAM address lines.
 */

package ram_map_pkg;

  // One of eight 64K banks on the card
  typedef logic [2:0] bank_t;

  // One 16K block inside a bank
  typedef logic [1:0] block_t;

  // Block schemes written in data bits 2:0 of a bank-select write
  typedef enum logic [2:0] {
    SCHEME_NONE    = 3'd0,
    SCHEME_HIGH    = 3'd1,
    SCHEME_LINEAR  = 3'd2,
    SCHEME_C3      = 3'd3,
    SCHEME_BANK1_0 = 3'd4,
    SCHEME_BANK1_1 = 3'd5,
    SCHEME_BANK1_2 = 3'd6,
    SCHEME_BANK1_3 = 3'd7
  } scheme_t;

  // Bank in bits 4:2 and block in bits 1:0 on the SRAM's top address lines
  typedef logic [4:0] ram_adr_hi_t;

  // Schemes 1 and 3 both place block 3 of the bank at C000
  localparam block_t BLOCK_TOP = 2'd3;

endpackage : ram_map_pkg

/* verilog/ram_map/bank_ctrl_regs.sv */
/*
 * Reset synchronizer and the I/O-written control registers:
 * bank, block scheme, card select and the two ROM-disable bits.
 */

module bank_ctrl_regs #(
  parameter bit io_port_adr8 = 1'b1
) (
  input  logic                   clk,
  input  logic                   reset_b,
  input  logic                   iorq_b,
  input  logic                   wr_b,
  input  logic                   adr15,
  input  logic                   adr8,
  input  cpc_bus_pkg::bus_data_t data,
  output logic                   sys_reset_b,
  output ram_map_pkg::bank_t     bank,
  output ram_map_pkg::scheme_t   scheme,
  output logic                   card_sel,
  output logic                   upper_rom_off,
  output logic                   lower_rom_off
);

  import cpc_bus_pkg::*;
  import ram_map_pkg::*;

  logic reset_sync1_b;
  logic reset_sync2_b;
  logic io_ctrl_wr;

  // Two flops bring the release of reset onto the clock.
  // The assertion edge still acts at once through reset_b itself
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      reset_sync1_b <= 1'b0;
      reset_sync2_b <= 1'b0;
    end else begin
      reset_sync1_b <= 1'b1;
      reset_sync2_b <= reset_sync1_b;
    end
  end

  assign sys_reset_b = reset_b & reset_sync1_b & reset_sync2_b;

  // Gate array port writes have A15 low; the code in data bits 7:6 picks the register
  assign io_ctrl_wr = !iorq_b && !wr_b && !adr15;

  // Sampled on the falling edge, well inside the I/O write where data is stable
  always_ff @(negedge clk or negedge sys_reset_b) begin
    if (!sys_reset_b) begin
      bank          <= '0;
      scheme        <= SCHEME_NONE;
      card_sel      <= 1'b0;
      upper_rom_off <= 1'b0;
      lower_rom_off <= 1'b0;
    end else if (io_ctrl_wr) begin
      if (data[7:6] == CTRL_CODE_RAM) begin
        bank     <= data[5:3];
        scheme   <= scheme_t'(data[2:0]);
        // A write to the other card's port deselects this one
        card_sel <= (adr8 == io_port_adr8);
      end else if (data[7:6] == CTRL_CODE_ROM) begin
        // Bit 3 disables the upper ROM, bit 2 the lower ROM
        upper_rom_off <= data[3];
        lower_rom_off <= data[2];
      end
    end
  end

endmodule : bank_ctrl_regs

/* verilog/ram_map/block_mapper.sv */
/*
 * Block-scheme table: maps the quadrant of an access to
 * an expansion block and the high SRAM address lines.
 */

module block_mapper (
  input  ram_map_pkg::bank_t       bank,
  input  ram_map_pkg::scheme_t     scheme,
  input  logic                     adr15,
  input  logic                     adr14,
  output logic                     map_hit,
  output ram_map_pkg::ram_adr_hi_t ram_adr_hi
);

  import cpc_bus_pkg::*;
  import ram_map_pkg::*;

  quadrant_t quad;
  block_t    block;

  assign quad = {adr15, adr14};

  // Table of the eight schemes, quadrant to block within the selected bank
  always_comb begin
    map_hit = 1'b0;
    block   = '0;
    unique case (scheme)
      SCHEME_NONE: begin
        // All four quadrants stay in internal RAM
        map_hit = 1'b0;
      end
      SCHEME_HIGH, SCHEME_C3: begin
        // Only the top quadrant is remapped, to block 3.
        // C3 also moves 4000 to internal C000 but that needs no card RAM
        map_hit = (quad == QUAD_HIGH_ROM);
        block   = BLOCK_TOP;
      end
      SCHEME_LINEAR: begin
        // The whole 64K bank replaces internal RAM
        map_hit = 1'b1;
        block   = quad;
      end
      SCHEME_BANK1_0, SCHEME_BANK1_1, SCHEME_BANK1_2, SCHEME_BANK1_3: begin
        // Any one block shows through the 4000-7FFF window,
        // named by the low two bits of the scheme
        map_hit = (quad == QUAD_BANK1);
        block   = scheme[1:0];
      end
      default: begin
        map_hit = 1'b0;
      end
    endcase
  end

  // Unused lines are held at zero when the access is not mapped
  assign ram_adr_hi = map_hit ? {bank, block} : '0;

endmodule : block_mapper

/* verilog/ram_strobe_gen.sv */
/*
 * SRAM strobe generator: memory-write cycle tracking,
 * ROM-overlap read decision, chip select, enables and ramdis.
 */

module ram_strobe_gen (
  input  logic clk,
  input  logic sys_reset_b,
  input  logic mreq_b,
  input  logic rfsh_b,
  input  logic rd_b,
  input  logic wr_b,
  input  logic adr15,
  input  logic adr14,
  input  logic map_hit,
  input  logic card_sel,
  input  logic upper_rom_off,
  input  logic lower_rom_off,
  output logic ramcs_b,
  output logic ramoe_b,
  output logic ramwe_b,
  output logic ramdis
);

  import cpc_bus_pkg::*;

  quadrant_t quad;
  logic      exp_sel;
  logic      ram_rd_ok;
  logic      mwr_cyc;
  logic      mwr_cyc_f;

  assign quad = {adr15, adr14};

  // The expansion owns this access only when the card is selected and the scheme maps it
  assign exp_sel = map_hit & card_sel;

  // A memory cycle with rd_b still high at the first rising edge is a write.
  // The flag holds until mreq_b is released
  always_ff @(posedge clk or negedge sys_reset_b) begin
    if (!sys_reset_b) begin
      mwr_cyc <= 1'b0;
    end else if (!mreq_b && rd_b) begin
      mwr_cyc <= 1'b1;
    end else if (mreq_b) begin
      mwr_cyc <= 1'b0;
    end
  end

  // Half a cycle later, so the write strobe opens once address and data have settled
  always_ff @(negedge clk or negedge sys_reset_b) begin
    if (!sys_reset_b) begin
      mwr_cyc_f <= 1'b0;
    end else begin
      mwr_cyc_f <= mwr_cyc;
    end
  end

  // RAM under a ROM may only be read with that ROM switched off
  always_comb begin
    unique case (quad)
      QUAD_LOW_ROM:  ram_rd_ok = lower_rom_off;
      QUAD_HIGH_ROM: ram_rd_ok = upper_rom_off;
      default:       ram_rd_ok = 1'b1;
    endcase
  end

  // Refresh cycles never reach the SRAM
  assign ramcs_b = !(exp_sel && !mreq_b && rfsh_b);
  assign ramoe_b = !(exp_sel && !mreq_b && rfsh_b && !rd_b && ram_rd_ok);
  assign ramwe_b = !(exp_sel && !wr_b && mwr_cyc && mwr_cyc_f);

  // Keep the internal RAM off the bus whenever the card claims the access
  assign ramdis = exp_sel;

endmodule : ram_strobe_gen

/* verilog/cpc_ram_expansion.sv */
/*
 * Top level of the 512K RAM expansion mapping logic.
 * Control registers, block mapper and SRAM strobe generator.
 */

module cpc_ram_expansion #(
  // Address bit 8 of the I/O port this card answers, 1 for 7Fxx and 0 for 7Exx
  parameter bit io_port_adr8 = 1'b1
) (
  input  logic                     clk,
  input  logic                     reset_b,
  input  logic                     rfsh_b,
  input  logic                     mreq_b,
  input  logic                     iorq_b,
  input  logic                     rd_b,
  input  logic                     wr_b,
  input  logic                     adr15,
  input  logic                     adr14,
  input  logic                     adr8,
  input  cpc_bus_pkg::bus_data_t   data,
  output logic                     ramcs_b,
  output logic                     ramoe_b,
  output logic                     ramwe_b,
  output logic                     ramdis,
  output ram_map_pkg::ram_adr_hi_t ramadrhi
);

  import ram_map_pkg::*;

  logic    sys_reset_b;
  bank_t   bank;
  scheme_t scheme;
  logic    card_sel;
  logic    upper_rom_off;
  logic    lower_rom_off;
  logic    map_hit;

  // Registers written by I/O control writes
  bank_ctrl_regs #(
    .io_port_adr8(io_port_adr8)
  ) i_bank_ctrl_regs (
    .clk          (clk),
    .reset_b      (reset_b),
    .iorq_b       (iorq_b),
    .wr_b         (wr_b),
    .adr15        (adr15),
    .adr8         (adr8),
    .data         (data),
    .sys_reset_b  (sys_reset_b),
    .bank         (bank),
    .scheme       (scheme),
    .card_sel     (card_sel),
    .upper_rom_off(upper_rom_off),
    .lower_rom_off(lower_rom_off)
  );

  // The high SRAM address lines come straight from the mapper
  block_mapper i_block_mapper (
    .bank      (bank),
    .scheme    (scheme),
    .adr15     (adr15),
    .adr14     (adr14),
    .map_hit   (map_hit),
    .ram_adr_hi(ramadrhi)
  );

  ram_strobe_gen i_ram_strobe_gen (
    .clk          (clk),
    .sys_reset_b  (sys_reset_b),
    .mreq_b       (mreq_b),
    .rfsh_b       (rfsh_b),
    .rd_b         (rd_b),
    .wr_b         (wr_b),
    .adr15        (adr15),
    .adr14        (adr14),
    .map_hit      (map_hit),
    .card_sel     (card_sel),
    .upper_rom_off(upper_rom_off),
    .lower_rom_off(lower_rom_off),
    .ramcs_b      (ramcs_b),
    .ramoe_b      (ramoe_b),
    .ramwe_b      (ramwe_b),
    .ramdis       (ramdis)
  );

endmodule : cpc_ram_expansion

/* dv/cpc_ram_expansion_properties.sv */
/*
 * Concurrent assertions on the SRAM strobes, bound into ram_strobe_gen.
 */

module cpc_ram_expansion_properties (
  input logic clk,
  input logic sys_reset_b,
  input logic wr_b,
  input logic rfsh_b,
  input logic ramcs_b,
  input logic ramwe_b,
  input logic ramdis
);

  // Number of assertion failures seen so far, watched by the testbench
  int fail_count = 0;

  // The SRAM is only written while the CPU drives wr_b
  assert property (@(posedge clk) disable iff (!sys_reset_b) wr_b |-> ramwe_b)
    else begin
      fail_count++;
      $error("ramwe_b low while wr_b is high");
    end

  // Refresh cycles must never select the SRAM
  assert property (@(posedge clk) disable iff (!sys_reset_b) !rfsh_b |-> ramcs_b)
    else begin
      fail_count++;
      $error("ramcs_b low during a refresh cycle");
    end

  // Internal RAM has to be off the bus whenever the card RAM is selected
  assert property (@(posedge clk) disable iff (!sys_reset_b) !ramcs_b |-> ramdis)
    else begin
      fail_count++;
      $error("ramdis low while ramcs_b is low");
    end

endmodule : cpc_ram_expansion_properties

bind ram_strobe_gen cpc_ram_expansion_properties i_properties (
  .clk        (clk),
  .sys_reset_b(sys_reset_b),
  .wr_b       (wr_b),
  .rfsh_b     (rfsh_b),
  .ramcs_b    (ramcs_b),
  .ramwe_b    (ramwe_b),
  .ramdis     (ramdis)
);

/* dv/cpc_ram_expansion_tb.sv */
/*
 * Directed testbench for the RAM expansion mapping logic.
 * Clock, reset, bus helper tasks, expected-value table and compare tasks.
 */

module cpc_ram_expansion_tb;

  import cpc_bus_pkg::*;
  import ram_map_pkg::*;

  localparam int MAX_CYCLES = 3000;

  logic        clk;
  logic        reset_b;
  logic        rfsh_b;
  logic        mreq_b;
  logic        iorq_b;
  logic        rd_b;
  logic        wr_b;
  logic        adr15;
  logic        adr14;
  logic        adr8;
  bus_data_t   data;
  logic        ramcs_b;
  logic        ramoe_b;
  logic        ramwe_b;
  logic        ramdis;
  ram_adr_hi_t ramadrhi;

  // Register contents the card should hold after the writes issued so far
  bank_t   m_bank;
  scheme_t m_scheme;
  logic    m_sel;
  logic    m_upper;
  logic    m_lower;
  int      cycles;

  cpc_ram_expansion #(
    .io_port_adr8(1'b1)
  ) i_dut (
    .clk     (clk),
    .reset_b (reset_b),
    .rfsh_b  (rfsh_b),
    .mreq_b  (mreq_b),
    .iorq_b  (iorq_b),
    .rd_b    (rd_b),
    .wr_b    (wr_b),
    .adr15   (adr15),
    .adr14   (adr14),
    .adr8    (adr8),
    .data    (data),
    .ramcs_b (ramcs_b),
    .ramoe_b (ramoe_b),
    .ramwe_b (ramwe_b),
    .ramdis  (ramdis),
    .ramadrhi(ramadrhi)
  );

  always #5 clk = ~clk;

  // Run length guard, far above what the directed tests need
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
      $display("Test FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // A failed strobe assertion in the bound checker ends the run
  always @(posedge clk) begin
    if (i_dut.i_ram_strobe_gen.i_properties.fail_count != 0) begin
      $display("A strobe assertion in the bound checker failed");
      $display("Test FAILED");
      $fatal(1, "assertion failure in the strobe checker");
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "compare on %s failed", name);
    end
  endtask

  task automatic check_adr_hi(input string name, input ram_adr_hi_t got, input ram_adr_hi_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "compare on %s failed", name);
    end
  endtask

  // Does the scheme place card RAM in this quadrant
  function automatic logic scheme_hits(input scheme_t s, input quadrant_t q);
    case (s)
      SCHEME_NONE:            return 1'b0;
      SCHEME_HIGH, SCHEME_C3: return q == 2'b11;
      SCHEME_LINEAR:          return 1'b1;
      default:                return q == 2'b01;
    endcase
  endfunction

  // Bank above the block, zero when the quadrant is not mapped
  function automatic ram_adr_hi_t expected_adr_hi(input bank_t b, input scheme_t s,
                                                  input quadrant_t q);
    logic [1:0] blk;
    if (!scheme_hits(s, q)) begin
      return '0;
    end
    case (s)
      SCHEME_HIGH, SCHEME_C3: blk = 2'd3;
      SCHEME_LINEAR:          blk = q;
      default:                blk = s[1:0];
    endcase
    return {b, blk};
  endfunction

  // RAM under a ROM is readable only with that ROM off
  function automatic logic read_allowed(input quadrant_t q);
    if (q == 2'b00) begin
      return m_lower;
    end else if (q == 2'b11) begin
      return m_upper;
    end
    return 1'b1;
  endfunction

  // One I/O write cycle with A15 low; the card samples it on the falling edge
  task automatic io_write(input logic a8, input bus_data_t d);
    @(posedge clk);
    #1;
    adr15  = 1'b0;
    adr8   = a8;
    data   = d;
    iorq_b = 1'b0;
    wr_b   = 1'b0;
    @(posedge clk);
    #1;
    iorq_b = 1'b1;
    wr_b   = 1'b1;
  endtask

  task automatic ram_select(input bank_t b, input scheme_t s, input logic a8);
    io_write(a8, {CTRL_CODE_RAM, b, s});
    m_bank   = b;
    m_scheme = s;
    m_sel    = a8;
  endtask

  task automatic rom_select(input logic upper_off, input logic lower_off);
    io_write(1'b1, {CTRL_CODE_ROM, 2'b00, upper_off, lower_off, 2'b00});
    m_upper = upper_off;
    m_lower = lower_off;
  endtask

  // Memory read, write or refresh cycle in quadrant q, checked once the
  // write strobe has had its falling edge to open
  task automatic mem_cycle(input quadrant_t q, input logic is_write, input logic refresh);
    logic hit;
    hit = m_sel && scheme_hits(m_scheme, q);
    @(posedge clk);
    #1;
    {adr15, adr14} = q;
    data   = 8'h5a;
    rfsh_b = !refresh;
    rd_b   = is_write || refresh;
    wr_b   = !is_write;
    mreq_b = 1'b0;
    @(posedge clk);
    @(negedge clk);
    #2;
    check_bit("ramdis", ramdis, hit);
    check_adr_hi("ramadrhi", ramadrhi, expected_adr_hi(m_bank, m_scheme, q));
    if (refresh) begin
      check_bit("ramcs_b", ramcs_b, 1'b1);
      check_bit("ramoe_b", ramoe_b, 1'b1);
      check_bit("ramwe_b", ramwe_b, 1'b1);
    end else begin
      check_bit("ramcs_b", ramcs_b, !hit);
      check_bit("ramoe_b", ramoe_b, !(hit && !is_write && read_allowed(q)));
      check_bit("ramwe_b", ramwe_b, !(hit && is_write));
    end
    @(posedge clk);
    #1;
    mreq_b = 1'b1;
    rd_b   = 1'b1;
    wr_b   = 1'b1;
    rfsh_b = 1'b1;
  endtask

  task automatic after_reset_idle();
    for (int q = 0; q < 4; q++) begin
      mem_cycle(quadrant_t'(q), 1'b0, 1'b0);
      mem_cycle(quadrant_t'(q), 1'b1, 1'b0);
    end
  endtask

  task automatic mapping_sweep();
    for (int s = 0; s < 8; s++) begin
      for (int rep = 0; rep < 2; rep++) begin
        ram_select(bank_t'($urandom % 8), scheme_t'(s), 1'b1);
        for (int q = 0; q < 4; q++) begin
          mem_cycle(quadrant_t'(q), 1'b0, 1'b0);
        end
      end
    end
  endtask

  task automatic foreign_port_deselect();
    ram_select(3'd6, SCHEME_LINEAR, 1'b0);
    for (int q = 0; q < 4; q++) begin
      mem_cycle(quadrant_t'(q), 1'b0, 1'b0);
      mem_cycle(quadrant_t'(q), 1'b1, 1'b0);
    end
    // Back on this card's own port the bank shows again
    ram_select(3'd5, SCHEME_LINEAR, 1'b1);
    for (int q = 0; q < 4; q++) begin
      mem_cycle(quadrant_t'(q), 1'b0, 1'b0);
    end
  endtask

  task automatic mem_write_strobe();
    ram_select(3'd2, SCHEME_HIGH, 1'b1);
    mem_cycle(QUAD_HIGH_ROM, 1'b1, 1'b0);
    mem_cycle(QUAD_BANK1, 1'b1, 1'b0);
    ram_select(3'd7, SCHEME_BANK1_2, 1'b1);
    mem_cycle(QUAD_BANK1, 1'b1, 1'b0);
    mem_cycle(QUAD_LOW_ROM, 1'b1, 1'b0);
  endtask

  task automatic rom_overlap_reads();
    ram_select(3'd3, SCHEME_LINEAR, 1'b1);
    for (int r = 0; r < 4; r++) begin
      rom_select(r[1], r[0]);
      for (int q = 0; q < 4; q++) begin
        mem_cycle(quadrant_t'(q), 1'b0, 1'b0);
      end
    end
  endtask

  task automatic refresh_no_select();
    ram_select(3'd1, SCHEME_LINEAR, 1'b1);
    for (int q = 0; q < 4; q++) begin
      mem_cycle(quadrant_t'(q), 1'b0, 1'b1);
    end
  endtask

  initial begin
    void'($urandom(32'hf66b9f8c));
    cycles   = 0;
    clk      = 1'b0;
    reset_b  = 1'b0;
    rfsh_b   = 1'b1;
    mreq_b   = 1'b1;
    iorq_b   = 1'b1;
    rd_b     = 1'b1;
    wr_b     = 1'b1;
    adr15    = 1'b0;
    adr14    = 1'b0;
    adr8     = 1'b1;
    data     = '0;
    m_bank   = '0;
    m_scheme = SCHEME_NONE;
    m_sel    = 1'b0;
    m_upper  = 1'b0;
    m_lower  = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset_b = 1'b1;
    // The synchronizer releases the registers two edges later
    repeat (3) @(posedge clk);
    after_reset_idle();
    mapping_sweep();
    foreign_port_deselect();
    mem_write_strobe();
    rom_overlap_reads();
    refresh_no_select();
    // The checker has evaluated the last rising edge by now
    @(negedge clk);
    if (i_dut.i_ram_strobe_gen.i_properties.fail_count != 0) begin
      $display("A strobe assertion in the bound checker failed");
      $display("Test FAILED");
      $fatal(1, "assertion failure in the strobe checker");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule : cpc_ram_expansion_tb

/* all.f */
common/cpc_bus_pkg.sv
common/ram_map_pkg.sv
verilog/ram_map/bank_ctrl_regs.sv
verilog/ram_map/block_mapper.sv
verilog/ram_strobe_gen.sv
verilog/cpc_ram_expansion.sv
dv/cpc_ram_expansion_properties.sv
dv/cpc_ram_expansion_tb.sv

/* Bender.yml */
package:
  name: cpc_ram_expansion

sources:
  - common/cpc_bus_pkg.sv
  - common/ram_map_pkg.sv
  - verilog/ram_map/bank_ctrl_regs.sv
  - verilog/ram_map/block_mapper.sv
  - verilog/ram_strobe_gen.sv
  - verilog/cpc_ram_expansion.sv
  - target: simulation
    files:
      - dv/cpc_ram_expansion_properties.sv
      - dv/cpc_ram_expansion_tb.sv
